//--- verilog/ht16_pkg.sv
package ht16_pkg;

	// ****************************************
	// Limits of the reduced table 16 code
	// ****************************************

	localparam int max_code_bits = 10;   // Longest kept codeword
	localparam int lin_bits = 1;         // Table 16 carries one linbit
	localparam int esc_abs = 15;         // Magnitude that calls for linbits

	// ****************************************
	// Types
	// ****************************************

	// Magnitude as it comes out of the table
	typedef logic [3:0] abs_t;

	// First collected bit sits in the top position
	typedef logic [max_code_bits-1:0] code_buf_t;

	// 0 to max_code_bits
	typedef logic [3:0] code_len_t;

	typedef logic [lin_bits-1:0] lin_t;

	typedef logic signed [15:0] coord_t;

	// Tail steps in reading order
	typedef enum logic [2:0] {
		idle,
		x_lin,
		x_sign,
		y_lin,
		y_sign,
		done
	} tail_state_t;

endpackage

//--- verilog/code_match_if.sv
interface code_match_if;

	logic match;                  // Codeword complete
	ht16_pkg::abs_t x_abs;
	ht16_pkg::abs_t y_abs;
	logic consume;                // Pair emitted so the collector clears

	modport collector (
		output match,
		output x_abs,
		output y_abs,
		input consume
	);

	modport reader (
		input match,
		input x_abs,
		input y_abs,
		output consume
	);

endinterface

//--- verilog/huff_table16.sv
module huff_table16 (
	input ht16_pkg::code_buf_t buffer,
	input ht16_pkg::code_len_t length,
	output logic hit,
	output ht16_pkg::abs_t x_abs,
	output ht16_pkg::abs_t y_abs
);

	logic [7:0] xy;   // x in the high nibble, y in the low

	assign x_abs = xy[7:4];
	assign y_abs = xy[3:0];

	// Only the top length bits take part in the compare
	always_comb begin
		hit = 1'b1;
		xy = 8'h00;
		case (length)
			4'd1: hit = buffer[9];   // "1" is (0,0)
			4'd3: begin
				case (buffer[9:7])
					3'b011: xy = 8'h10;
					default: hit = 1'b0;
				endcase
			end
			4'd4: begin
				case (buffer[9:6])
					4'b0101: xy = 8'h01;
					4'b0100: xy = 8'h11;
					default: hit = 1'b0;
				endcase
			end
			4'd6: begin
				case (buffer[9:4])
					6'b001110: xy = 8'h02;
					6'b001100: xy = 8'h12;
					6'b001111: xy = 8'h20;
					6'b001101: xy = 8'h21;
					default: hit = 1'b0;
				endcase
			end
			4'd7: begin
				case (buffer[9:3])
					7'b0010100: xy = 8'h13;
					7'b0010111: xy = 8'h22;
					7'b0010101: xy = 8'h31;
					default: hit = 1'b0;
				endcase
			end
			4'd8: begin
				case (buffer[9:2])
					8'b00101100: xy = 8'h03;
					8'b00100011: xy = 8'h14;
					8'b00001001: xy = 8'h1f;
					8'b00100110: xy = 8'h23;
					8'b00101101: xy = 8'h30;
					8'b00100111: xy = 8'h32;
					8'b00100100: xy = 8'h41;
					8'b00011110: xy = 8'h51;
					8'b00001010: xy = 8'hf1;
					8'b00000111: xy = 8'hf2;
					8'b00000011: xy = 8'hff;
					default: hit = 1'b0;
				endcase
			end
			4'd9: begin
				case (buffer[9:1])
					9'b001001010: xy = 8'h04;
					9'b000111111: xy = 8'h05;
					9'b000010001: xy = 8'h0f;
					9'b000111110: xy = 8'h15;
					9'b000110101: xy = 8'h16;
					9'b000101111: xy = 8'h17;
					9'b001000011: xy = 8'h24;
					9'b000111010: xy = 8'h25;
					9'b000010000: xy = 8'h2f;
					9'b001000101: xy = 8'h33;
					9'b001000000: xy = 8'h34;
					9'b001001011: xy = 8'h40;
					9'b001000100: xy = 8'h42;
					9'b001000001: xy = 8'h43;
					9'b000001001: xy = 8'h4f;
					9'b001000010: xy = 8'h50;
					9'b000111011: xy = 8'h52;
					9'b000111000: xy = 8'h53;
					9'b000110110: xy = 8'h61;
					9'b000110100: xy = 8'h62;
					9'b000110000: xy = 8'h71;
					9'b000001100: xy = 8'hf0;
					9'b000001011: xy = 8'hf3;
					9'b000001010: xy = 8'hf4;
					default: hit = 1'b0;
				endcase
			end
			4'd10: begin
				case (buffer[9:0])
					10'b0001101110: xy = 8'h06;
					10'b0001011101: xy = 8'h07;
					10'b0001010011: xy = 8'h18;
					10'b0001001011: xy = 8'h19;
					10'b0001000100: xy = 8'h1a;
					10'b0001100111: xy = 8'h26;
					10'b0001011010: xy = 8'h27;
					10'b0001001000: xy = 8'h29;
					10'b0001110010: xy = 8'h35;
					10'b0001100011: xy = 8'h36;
					10'b0001010111: xy = 8'h37;
					10'b0000011010: xy = 8'h3f;
					10'b0001110011: xy = 8'h44;
					10'b0001100101: xy = 8'h45;
					10'b0001100110: xy = 8'h54;
					10'b0000010000: xy = 8'h5f;
					10'b0001101111: xy = 8'h60;
					10'b0001100100: xy = 8'h63;
					10'b0000001010: xy = 8'h6f;
					10'b0001100010: xy = 8'h70;
					10'b0001011011: xy = 8'h72;
					10'b0001011000: xy = 8'h73;
					10'b0000001000: xy = 8'h7f;
					10'b0001010101: xy = 8'h80;
					10'b0001010100: xy = 8'h81;
					10'b0001010001: xy = 8'h82;
					10'b0000000111: xy = 8'h8f;
					10'b0001001100: xy = 8'h91;
					10'b0001001001: xy = 8'h92;
					10'b0001000011: xy = 8'ha2;
					10'b0000000100: xy = 8'haf;
					10'b0000010001: xy = 8'hf5;
					10'b0000001011: xy = 8'hf6;
					10'b0000001001: xy = 8'hf7;
					default: hit = 1'b0;
				endcase
			end
			default: hit = 1'b0;   // No codes of length 0, 2 or 5
		endcase
	end

endmodule

//--- verilog/huff_code_collector.sv
module huff_code_collector (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_bit,
	output logic code_error,
	code_match_if.collector match
);

	ht16_pkg::code_buf_t buffer;
	ht16_pkg::code_len_t length;
	logic hit;
	logic restart;

	huff_table16 u_table (
		.buffer(buffer),
		.length(length),
		.hit(hit),
		.x_abs(match.x_abs),
		.y_abs(match.y_abs)
	);

	assign match.match = hit;

	// Full buffer and still nothing matched
	assign code_error = (length == ht16_pkg::max_code_bits) && !hit;

	// Either way the bit taken now opens a new codeword
	assign restart = match.consume || code_error;

	// ****************************************
	// Length counter
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			length <= '0;
		end else if (restart) begin
			length <= in_valid ? 4'd1 : 4'd0;
		end else if (in_valid && !hit) begin
			length <= length + 4'd1;
		end
	end

	// Codeword bits fill the buffer from the top
	always_ff @(posedge clk) begin
		if (restart) begin
			if (in_valid)
				buffer[ht16_pkg::max_code_bits-1] <= in_bit;
		end else if (in_valid && !hit) begin
			buffer[ht16_pkg::max_code_bits-1-length] <= in_bit;
		end
	end

endmodule

//--- verilog/escape_sign_reader.sv
module escape_sign_reader (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_bit,
	output logic pair_valid,
	output ht16_pkg::coord_t x_val,
	output ht16_pkg::coord_t y_val,
	code_match_if.reader match
);

	ht16_pkg::tail_state_t state;
	ht16_pkg::tail_state_t step;   // Step the next accepted bit belongs to
	ht16_pkg::lin_t x_linval;
	ht16_pkg::lin_t y_linval;
	logic x_neg;
	logic y_neg;

	// Next tail step after s that the magnitudes call for
	function automatic ht16_pkg::tail_state_t next_after(
		input ht16_pkg::tail_state_t s,
		input ht16_pkg::abs_t xa,
		input ht16_pkg::abs_t ya
	);
		ht16_pkg::tail_state_t n;
		if (s == ht16_pkg::idle && xa == ht16_pkg::esc_abs)
			n = ht16_pkg::x_lin;
		else if (s inside {ht16_pkg::idle, ht16_pkg::x_lin} && xa != 0)
			n = ht16_pkg::x_sign;
		else if (s inside {ht16_pkg::idle, ht16_pkg::x_lin, ht16_pkg::x_sign}
				&& ya == ht16_pkg::esc_abs)
			n = ht16_pkg::y_lin;
		else if (s != ht16_pkg::y_sign && s != ht16_pkg::done && ya != 0)
			n = ht16_pkg::y_sign;
		else
			n = ht16_pkg::done;
		return n;
	endfunction

	function automatic ht16_pkg::coord_t to_coord(
		input ht16_pkg::abs_t a,
		input ht16_pkg::lin_t l,
		input logic neg
	);
		ht16_pkg::coord_t mag;
		mag = ht16_pkg::coord_t'(a);
		if (a == ht16_pkg::esc_abs)
			mag = mag + ht16_pkg::coord_t'(l);
		if (a != 0 && neg)   // Zero magnitude has no sign bit
			mag = -mag;
		return mag;
	endfunction

	always_comb begin
		if (state == ht16_pkg::idle)
			step = next_after(ht16_pkg::idle, match.x_abs, match.y_abs);
		else
			step = state;
		pair_valid = match.match && step == ht16_pkg::done;
		match.consume = pair_valid;
	end

	assign x_val = to_coord(match.x_abs, x_linval, x_neg);
	assign y_val = to_coord(match.y_abs, y_linval, y_neg);

	// ****************************************
	// Tail FSM
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ht16_pkg::idle;
		end else if (pair_valid) begin
			state <= ht16_pkg::idle;   // Bit in this cycle goes to the collector
		end else if (match.match && in_valid) begin
			state <= next_after(step, match.x_abs, match.y_abs);
		end
	end

	always_ff @(posedge clk) begin
		if (match.match && in_valid && !pair_valid) begin
			case (step)
				ht16_pkg::x_lin: x_linval <= ht16_pkg::lin_t'(in_bit);
				ht16_pkg::x_sign: x_neg <= in_bit;
				ht16_pkg::y_lin: y_linval <= ht16_pkg::lin_t'(in_bit);
				ht16_pkg::y_sign: y_neg <= in_bit;
				default: ;
			endcase
		end
	end

endmodule

//--- verilog/ht16_decoder.sv
module ht16_decoder (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_bit,
	output logic pair_valid,
	output ht16_pkg::coord_t x_val,
	output ht16_pkg::coord_t y_val,
	output logic code_error
);

	// Matched codeword from collector to tail reader
	code_match_if code_if ();

	// ****************************************
	// Codeword collection and lookup
	// ****************************************

	huff_code_collector u_collector (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_bit(in_bit),
		.code_error(code_error),
		.match(code_if.collector)
	);

	// ****************************************
	// Linbits, signs and output pair
	// ****************************************

	escape_sign_reader u_reader (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_bit(in_bit),
		.pair_valid(pair_valid),
		.x_val(x_val),
		.y_val(y_val),
		.match(code_if.reader)
	);

endmodule

//--- bench/tb_ht16_decoder.sv
module tb_ht16_decoder;

	timeunit 1ns;
	timeprecision 1ps;

	localparam string trace_file = "bench/ht16_trace.txt";
	localparam int max_records = 64;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_bit;
	logic pair_valid;
	ht16_pkg::coord_t x_val;
	ht16_pkg::coord_t y_val;
	logic code_error;

	// Trace contents
	string rec_bits [0:max_records-1];
	int rec_x [0:max_records-1];
	int rec_y [0:max_records-1];
	bit rec_err [0:max_records-1];
	int rec_count;
	int total_bits;

	int cycle_count;
	int cycle_limit;

	ht16_decoder dut (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_bit(in_bit),
		.pair_valid(pair_valid),
		.x_val(x_val),
		.y_val(y_val),
		.code_error(code_error)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ****************************************
	// Watchdog
	// ****************************************

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: no result from the DUT after %0d cycles", cycle_count);
			$display("Verification failed");
			$fatal(1, "Run stopped by the watchdog");
		end
	end

	// ****************************************
	// Compare tasks
	// ****************************************

	task automatic check_coord(input string name, input ht16_pkg::coord_t exp,
			input ht16_pkg::coord_t act);
		if (act !== exp) begin
			$display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
			$display("Verification failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
			$display("Verification failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	// Neither output may pulse mid codeword
	task automatic expect_quiet();
		check_flag("pair_valid", 1'b0, pair_valid);
		check_flag("code_error", 1'b0, code_error);
	endtask

	// ****************************************
	// Trace reading
	// ****************************************

	function automatic int to_int(input string s);
		string digits;
		int v;
		if (s.getc(0) == "-") begin
			digits = s.substr(1, s.len() - 1);
			v = -digits.atoi();
		end else begin
			v = s.atoi();
		end
		return v;
	endfunction

	task automatic parse_line(input string line);
		string tok [0:3];
		int ntok;
		int start;
		byte c;
		ntok = 0;
		start = -1;
		for (int k = 0; k <= line.len(); k++) begin
			c = (k < line.len()) ? line.getc(k) : " ";
			if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
				if (start >= 0 && ntok < 4) begin
					tok[ntok] = line.substr(start, k - 1);
					ntok++;
				end
				start = -1;
			end else if (start < 0) begin
				start = k;
			end
		end
		if (ntok == 0 || tok[0].getc(0) == "#")
			return;   // Blank or comment
		if (rec_count >= max_records) begin
			$display("Trace holds more records than the testbench can store");
			$display("Verification failed");
			$fatal(1, "Trace too long");
		end
		rec_bits[rec_count] = tok[0];
		total_bits += tok[0].len();
		if (ntok == 2 && tok[1] == "error") begin
			rec_err[rec_count] = 1'b1;
			rec_x[rec_count] = 0;
			rec_y[rec_count] = 0;
		end else if (ntok == 3) begin
			rec_err[rec_count] = 1'b0;
			rec_x[rec_count] = to_int(tok[1]);
			rec_y[rec_count] = to_int(tok[2]);
		end else begin
			$display("Trace line is malformed: %s", line);
			$display("Verification failed");
			$fatal(1, "Bad trace");
		end
		rec_count++;
	endtask

	task automatic load_trace();
		int fd;
		string line;
		fd = $fopen(trace_file, "r");
		if (fd == 0) begin
			$display("Could not open the trace file %s", trace_file);
			$display("Verification failed");
			$fatal(1, "No trace");
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) != 0)
				parse_line(line);
		end
		$fclose(fd);
	endtask

	// ****************************************
	// Stimulus
	// ****************************************

	task automatic feed_record(input int idx);
		string bits;
		int gaps;
		int n;
		bits = rec_bits[idx];
		n = bits.len();
		for (int i = 0; i < n; i++) begin
			// Odd records start in the result cycle of the one before
			if (i == 0 && idx % 2 == 1)
				gaps = 0;
			else
				gaps = $urandom_range(3, 0);
			repeat (gaps) begin
				in_valid = 1'b0;
				in_bit = 1'b0;
				@(negedge clk);
				expect_quiet();
			end
			in_valid = 1'b1;
			in_bit = (bits.getc(i) == "1");
			@(negedge clk);
			if (i != n - 1)
				expect_quiet();
		end
		while (!pair_valid && !code_error) begin
			in_valid = 1'b0;
			in_bit = 1'b0;
			@(negedge clk);
		end
		if (rec_err[idx]) begin
			check_flag("code_error", 1'b1, code_error);
			check_flag("pair_valid", 1'b0, pair_valid);
		end else begin
			check_flag("pair_valid", 1'b1, pair_valid);
			check_flag("code_error", 1'b0, code_error);
			check_coord("x_val", ht16_pkg::coord_t'(rec_x[idx]), x_val);
			check_coord("y_val", ht16_pkg::coord_t'(rec_y[idx]), y_val);
		end
	endtask

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_bit = 1'b0;
		cycle_count = 0;
		rec_count = 0;
		total_bits = 0;
		void'($urandom(75870));
		load_trace();
		cycle_limit = total_bits * 4 + 100;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		expect_quiet();
		for (int r = 0; r < rec_count; r++)
			feed_record(r);
		in_valid = 1'b0;
		in_bit = 1'b0;
		@(negedge clk);
		expect_quiet();   // Last result lasted one cycle
		$display("Verification passed");
		$finish;
	end

endmodule

//--- bench/ht16_trace.txt
# Columns: codeword and tail bits (first bit left), then expected x and y
# or the word error when ten bits match no kept code
1 0 0
010001 1 -1
0010011010 -2 3
0111 -1 0
01010 0 1
0011101 0 -2
001011101 2 -2
001010111 -3 -1
001011000 0 3
0010001110 -1 4
0010010001 4 -1
0001111000 5 1
0010010101 0 -4
00011111001 1 -5
00100010110 -3 3
00011011101 0 -6
00010111010 0 7
000110011111 -2 -6
000100001101 10 -2
00001010110 -16 1
00001010001 15 -1
00000110010 16 0
00000110001 -15 0
00001001011 1 -16
00001000110 0 16
0000011010100 -3 15
000000111111 -16 -16
000000110010 15 16
000001011101 16 -3
0000000100011 10 -16
0000000000 error
1 0 0
0000011011 error
010011 -1 -1
0001000101 error
0010011001 2 -3
1 0 0
1 0 0
0000000001 error
0000001010101 -6 -15
00010101011 -8 0
000100110000 9 1
0110 1 0
00110110 -2 1

//--- list.f
verilog/ht16_pkg.sv
verilog/code_match_if.sv
verilog/huff_table16.sv
verilog/huff_code_collector.sv
verilog/escape_sign_reader.sv
verilog/ht16_decoder.sv
bench/tb_ht16_decoder.sv

//--- Bender.yml
package:
  name: ht16_decoder

sources:
  - files:
      - verilog/ht16_pkg.sv
      - verilog/code_match_if.sv
      - verilog/huff_table16.sv
      - verilog/huff_code_collector.sv
      - verilog/escape_sign_reader.sv
      - verilog/ht16_decoder.sv
  - target: test
    files:
      - bench/tb_ht16_decoder.sv
